// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_secure_ss
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bus_isolate.sv ====
`default_nettype none

module bus_isolate
   import ss_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     isolate_i,
   // From the upsizer
   input  logic                     w_req_valid_i,
   output logic                     w_req_ready_o,
   input  logic [AddrWidth-1:0]     w_req_addr_i,
   input  logic                     w_req_we_i,
   input  wide_data_t               w_req_wdata_i,
   input  logic [WideBeWidth-1:0]   w_req_be_i,
   output logic                     w_rsp_valid_o,
   input  logic                     w_rsp_ready_i,
   output wide_data_t               w_rsp_rdata_o,
   output logic                     w_rsp_err_o,
   // Outbound
   output logic                     m_req_valid_o,
   input  logic                     m_req_ready_i,
   output logic [AddrWidth-1:0]     m_req_addr_o,
   output logic                     m_req_we_o,
   output logic [WideDataWidth-1:0] m_req_wdata_o,
   output logic [WideBeWidth-1:0]   m_req_be_o,
   input  logic                     m_rsp_valid_i,
   output logic                     m_rsp_ready_o,
   input  logic [WideDataWidth-1:0] m_rsp_rdata_i,
   input  logic                     m_rsp_err_i,
   output logic                     isolated_o
);

   logic [1:0]                 state_q;
   logic [1:0]                 state_d;
   logic [PendingCntWidth-1:0] pending_q;
   logic                       pending_full;
   logic                       m_req_done;
   logic                       m_rsp_done;
   logic                       err_valid_q;
   logic                       err_accept;

   assign pending_full = pending_q == PendingCntWidth'(MaxPending);
   assign m_req_done   = m_req_valid_o && m_req_ready_i;
   assign m_rsp_done   = m_rsp_valid_i && m_rsp_ready_o;
   assign err_accept   = (state_q == IsoActive) && w_req_valid_i && !err_valid_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IsoNormal: begin
            if (isolate_i) begin
               state_d = IsoDrain;
            end
         end
         IsoDrain: begin
            if (!isolate_i) begin
               state_d = IsoNormal;
            end else if (pending_q == '0) begin
               state_d = IsoActive;
            end
         end
         IsoActive: begin
            if (!isolate_i) begin
               state_d = IsoNormal;
            end
         end
         default: state_d = IsoNormal;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         // Matches the isolate synchronizer, which resets high
         state_q     <= IsoActive;
         pending_q   <= '0;
         err_valid_q <= 1'b0;
      end else begin
         state_q <= state_d;
         case ({m_req_done, m_rsp_done})
            2'b10:   pending_q <= pending_q + 1'b1;
            2'b01:   pending_q <= pending_q - 1'b1;
            default: pending_q <= pending_q;
         endcase
         if (err_accept) begin
            err_valid_q <= 1'b1;
         end else if (w_rsp_ready_i) begin
            err_valid_q <= 1'b0;
         end
      end
   end

   // Requests only leave in normal state and below the pending limit
   assign m_req_valid_o = (state_q == IsoNormal) && w_req_valid_i && !pending_full;
   assign m_req_addr_o  = w_req_addr_i;
   assign m_req_we_o    = w_req_we_i;
   assign m_req_wdata_o = w_req_wdata_i.word;
   assign m_req_be_o    = w_req_be_i;

   always_comb begin
      case (state_q)
         IsoNormal: w_req_ready_o = m_req_ready_i && !pending_full;
         IsoActive: w_req_ready_o = !err_valid_q;
         default:   w_req_ready_o = 1'b0;
      endcase
   end

   // A local error response is always older than any outbound one
   assign w_rsp_valid_o      = err_valid_q || m_rsp_valid_i;
   assign m_rsp_ready_o      = !err_valid_q && w_rsp_ready_i;
   assign w_rsp_rdata_o.word = err_valid_q ? '0 : m_rsp_rdata_i;
   assign w_rsp_err_o        = err_valid_q || m_rsp_err_i;

   assign isolated_o = state_q == IsoActive;

endmodule

`default_nettype wire

// ==== bus_upsizer.sv ====
`default_nettype none

module bus_upsizer
   import ss_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_i,
   // Core side
   input  logic                       s_req_valid_i,
   output logic                       s_req_ready_o,
   input  logic [AddrWidth-1:0]       s_req_addr_i,
   input  logic                       s_req_we_i,
   input  logic [NarrowDataWidth-1:0] s_req_wdata_i,
   input  logic [NarrowBeWidth-1:0]   s_req_be_i,
   output logic                       s_rsp_valid_o,
   input  logic                       s_rsp_ready_i,
   output logic [NarrowDataWidth-1:0] s_rsp_rdata_o,
   output logic                       s_rsp_err_o,
   // Wide side
   output logic                       w_req_valid_o,
   input  logic                       w_req_ready_i,
   output logic [AddrWidth-1:0]       w_req_addr_o,
   output logic                       w_req_we_o,
   output wide_data_t                 w_req_wdata_o,
   output logic [WideBeWidth-1:0]     w_req_be_o,
   input  logic                       w_rsp_valid_i,
   output logic                       w_rsp_ready_o,
   input  wide_data_t                 w_rsp_rdata_i,
   input  logic                       w_rsp_err_i
);

   logic                     req_valid_q;
   logic [AddrWidth-1:0]     req_addr_q;
   logic                     req_we_q;
   wide_data_t               req_wdata_q;
   logic [WideBeWidth-1:0]   req_be_q;

   wide_data_t               wdata_d;
   logic [WideBeWidth-1:0]   be_d;
   logic                     lane_sel;

   logic [LaneFifoDepth-1:0] lane_mem;
   logic [LanePtrWidth-1:0]  wr_ptr_q;
   logic [LanePtrWidth-1:0]  rd_ptr_q;
   logic [LaneCntWidth-1:0]  lane_cnt_q;
   logic                     lane_full;
   logic                     req_accept;
   logic                     rsp_done;

   assign lane_sel   = s_req_addr_i[LaneSelBit];
   assign lane_full  = lane_cnt_q == LaneCntWidth'(LaneFifoDepth);
   assign s_req_ready_o = (!req_valid_q || w_req_ready_i) && !lane_full;
   assign req_accept = s_req_valid_i && s_req_ready_o;
   assign rsp_done   = s_rsp_valid_o && s_rsp_ready_i;

   // Steer narrow data and byte enables into the addressed half
   always_comb begin
      wdata_d.word           = '0;
      wdata_d.lane[lane_sel] = s_req_wdata_i;
      if (lane_sel) begin
         be_d = {s_req_be_i, {NarrowBeWidth{1'b0}}};
      end else begin
         be_d = {{NarrowBeWidth{1'b0}}, s_req_be_i};
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         req_valid_q <= 1'b0;
      end else if (req_accept) begin
         req_valid_q <= 1'b1;
      end else if (w_req_ready_i) begin
         req_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_accept) begin
         req_addr_q  <= s_req_addr_i;
         req_we_q    <= s_req_we_i;
         req_wdata_q <= wdata_d;
         req_be_q    <= be_d;
      end
   end

   assign w_req_valid_o = req_valid_q;
   assign w_req_addr_o  = req_addr_q;
   assign w_req_we_o    = req_we_q;
   assign w_req_wdata_o = req_wdata_q;
   assign w_req_be_o    = req_be_q;

   // Lane of every request still waiting for its response
   always_ff @(posedge clk_i) begin
      if (req_accept) begin
         lane_mem[wr_ptr_q] <= lane_sel;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         lane_cnt_q <= '0;
      end else begin
         if (req_accept) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rsp_done) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({req_accept, rsp_done})
            2'b10:   lane_cnt_q <= lane_cnt_q + 1'b1;
            2'b01:   lane_cnt_q <= lane_cnt_q - 1'b1;
            default: lane_cnt_q <= lane_cnt_q;
         endcase
      end
   end

   // Response passes straight through, lane picked by the oldest entry
   assign s_rsp_valid_o = w_rsp_valid_i;
   assign w_rsp_ready_o = s_rsp_ready_i;
   assign s_rsp_rdata_o = w_rsp_rdata_i.lane[lane_mem[rd_ptr_q]];
   assign s_rsp_err_o   = w_rsp_err_i;

endmodule

`default_nettype wire

// ==== ctrl_input_sync.sv ====
`default_nettype none

module ctrl_input_sync
   import ss_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   input  logic fetch_en_i,
   input  logic irq_i,
   input  logic isolate_i,
   output logic fetch_en_o,
   output logic irq_o,
   output logic isolate_o
);

   logic [SyncStages-1:0] fetch_en_q;
   logic [SyncStages-1:0] irq_q;
   logic [SyncStages-1:0] isolate_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         fetch_en_q <= '0;
         irq_q      <= '0;
         // Come out of reset isolated
         isolate_q  <= '1;
      end else begin
         fetch_en_q <= {fetch_en_q[SyncStages-2:0], fetch_en_i};
         irq_q      <= {irq_q[SyncStages-2:0], irq_i};
         isolate_q  <= {isolate_q[SyncStages-2:0], isolate_i};
      end
   end

   assign fetch_en_o = fetch_en_q[SyncStages-1];
   assign irq_o      = irq_q[SyncStages-1];
   assign isolate_o  = isolate_q[SyncStages-1];

endmodule

`default_nettype wire

// ==== project.f ====
ss_pkg.sv
ctrl_input_sync.sv
bus_upsizer.sv
bus_isolate.sv
secure_ss_top.sv
tb_secure_ss.sv

// ==== secure_ss_top.sv ====
`default_nettype none

module secure_ss_top
   import ss_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       fetch_en_i,
   input  logic                       irq_i,
   input  logic                       axi_isolate_i,
   output logic                       fetch_en_o,
   output logic                       irq_o,
   output logic                       axi_isolated_o,
   // Core side
   input  logic                       s_req_valid_i,
   output logic                       s_req_ready_o,
   input  logic [AddrWidth-1:0]       s_req_addr_i,
   input  logic                       s_req_we_i,
   input  logic [NarrowDataWidth-1:0] s_req_wdata_i,
   input  logic [NarrowBeWidth-1:0]   s_req_be_i,
   output logic                       s_rsp_valid_o,
   input  logic                       s_rsp_ready_i,
   output logic [NarrowDataWidth-1:0] s_rsp_rdata_o,
   output logic                       s_rsp_err_o,
   // Outbound
   output logic                       m_req_valid_o,
   input  logic                       m_req_ready_i,
   output logic [AddrWidth-1:0]       m_req_addr_o,
   output logic                       m_req_we_o,
   output logic [WideDataWidth-1:0]   m_req_wdata_o,
   output logic [WideBeWidth-1:0]     m_req_be_o,
   input  logic                       m_rsp_valid_i,
   output logic                       m_rsp_ready_o,
   input  logic [WideDataWidth-1:0]   m_rsp_rdata_i,
   input  logic                       m_rsp_err_i
);

   logic                   isolate_sync;

   logic                   w_req_valid;
   logic                   w_req_ready;
   logic [AddrWidth-1:0]   w_req_addr;
   logic                   w_req_we;
   wide_data_t             w_req_wdata;
   logic [WideBeWidth-1:0] w_req_be;
   logic                   w_rsp_valid;
   logic                   w_rsp_ready;
   wide_data_t             w_rsp_rdata;
   logic                   w_rsp_err;

   ctrl_input_sync i_ctrl_sync (
      .clk_i      ( clk_i         ),
      .rst_i      ( rst_i         ),
      .fetch_en_i ( fetch_en_i    ),
      .irq_i      ( irq_i         ),
      .isolate_i  ( axi_isolate_i ),
      .fetch_en_o ( fetch_en_o    ),
      .irq_o      ( irq_o         ),
      .isolate_o  ( isolate_sync  )
   );

   bus_upsizer i_upsizer (
      .clk_i         ( clk_i         ),
      .rst_i         ( rst_i         ),
      .s_req_valid_i ( s_req_valid_i ),
      .s_req_ready_o ( s_req_ready_o ),
      .s_req_addr_i  ( s_req_addr_i  ),
      .s_req_we_i    ( s_req_we_i    ),
      .s_req_wdata_i ( s_req_wdata_i ),
      .s_req_be_i    ( s_req_be_i    ),
      .s_rsp_valid_o ( s_rsp_valid_o ),
      .s_rsp_ready_i ( s_rsp_ready_i ),
      .s_rsp_rdata_o ( s_rsp_rdata_o ),
      .s_rsp_err_o   ( s_rsp_err_o   ),
      .w_req_valid_o ( w_req_valid   ),
      .w_req_ready_i ( w_req_ready   ),
      .w_req_addr_o  ( w_req_addr    ),
      .w_req_we_o    ( w_req_we      ),
      .w_req_wdata_o ( w_req_wdata   ),
      .w_req_be_o    ( w_req_be      ),
      .w_rsp_valid_i ( w_rsp_valid   ),
      .w_rsp_ready_o ( w_rsp_ready   ),
      .w_rsp_rdata_i ( w_rsp_rdata   ),
      .w_rsp_err_i   ( w_rsp_err     )
   );

   bus_isolate i_isolate (
      .clk_i         ( clk_i          ),
      .rst_i         ( rst_i          ),
      .isolate_i     ( isolate_sync   ),
      .w_req_valid_i ( w_req_valid    ),
      .w_req_ready_o ( w_req_ready    ),
      .w_req_addr_i  ( w_req_addr     ),
      .w_req_we_i    ( w_req_we       ),
      .w_req_wdata_i ( w_req_wdata    ),
      .w_req_be_i    ( w_req_be       ),
      .w_rsp_valid_o ( w_rsp_valid    ),
      .w_rsp_ready_i ( w_rsp_ready    ),
      .w_rsp_rdata_o ( w_rsp_rdata    ),
      .w_rsp_err_o   ( w_rsp_err      ),
      .m_req_valid_o ( m_req_valid_o  ),
      .m_req_ready_i ( m_req_ready_i  ),
      .m_req_addr_o  ( m_req_addr_o   ),
      .m_req_we_o    ( m_req_we_o     ),
      .m_req_wdata_o ( m_req_wdata_o  ),
      .m_req_be_o    ( m_req_be_o     ),
      .m_rsp_valid_i ( m_rsp_valid_i  ),
      .m_rsp_ready_o ( m_rsp_ready_o  ),
      .m_rsp_rdata_i ( m_rsp_rdata_i  ),
      .m_rsp_err_i   ( m_rsp_err_i    ),
      .isolated_o    ( axi_isolated_o )
   );

endmodule

`default_nettype wire

// ==== ss_pkg.sv ====
`default_nettype none

package ss_pkg;

   // Bus widths
   localparam int unsigned NarrowDataWidth = 32;
   localparam int unsigned WideDataWidth   = 64;
   localparam int unsigned AddrWidth       = 32;
   localparam int unsigned NarrowBeWidth   = NarrowDataWidth / 8;
   localparam int unsigned WideBeWidth     = WideDataWidth / 8;
   localparam int unsigned NumLanes        = WideDataWidth / NarrowDataWidth;

   // Address bit that picks the 32-bit lane of a 64-bit word
   localparam int unsigned LaneSelBit      = $clog2(NarrowBeWidth);

   // Upsizer lane memory
   localparam int unsigned LaneFifoDepth   = 4;
   localparam int unsigned LanePtrWidth    = $clog2(LaneFifoDepth);
   localparam int unsigned LaneCntWidth    = $clog2(LaneFifoDepth + 1);

   // Isolator
   localparam int unsigned MaxPending      = 8;
   localparam int unsigned PendingCntWidth = 4;
   localparam logic [1:0]  IsoNormal       = 2'd0;
   localparam logic [1:0]  IsoDrain        = 2'd1;
   localparam logic [1:0]  IsoActive       = 2'd2;

   // Control input synchronizers
   localparam int unsigned SyncStages      = 3;

   // One outbound data word, seen whole or per lane
   typedef union packed {
      logic [WideDataWidth-1:0]                word;
      logic [NumLanes-1:0][NarrowDataWidth-1:0] lane;
   } wide_data_t;

endpackage

`default_nettype wire

// ==== tb_secure_ss.sv ====
`default_nettype none

module tb_secure_ss
   import ss_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ClkPeriod   = 100;
   localparam int Quarter     = ClkPeriod / 4;
   localparam int ResetCycles = 5;
   localparam int Seed        = 48259;
   localparam int NumOps      = 20;
   localparam int MemWords    = 32;
   // Requests of both traffic phases and the isolation batch, plus control checks
   localparam int TotalTests  = 2 * (2 * NumOps + NumOps / 4) + 6 + 8;
   localparam int CycleBound  = 40;
   localparam int SyncBound   = 12;
   localparam int IdleBound   = 200;

   logic                       clk_i;
   logic                       rst_i;
   logic                       fetch_en_i;
   logic                       irq_i;
   logic                       axi_isolate_i;
   logic                       fetch_en_o;
   logic                       irq_o;
   logic                       axi_isolated_o;
   logic                       s_req_valid_i;
   logic                       s_req_ready_o;
   logic [AddrWidth-1:0]       s_req_addr_i;
   logic                       s_req_we_i;
   logic [NarrowDataWidth-1:0] s_req_wdata_i;
   logic [NarrowBeWidth-1:0]   s_req_be_i;
   logic                       s_rsp_valid_o;
   logic                       s_rsp_ready_i;
   logic [NarrowDataWidth-1:0] s_rsp_rdata_o;
   logic                       s_rsp_err_o;
   logic                       m_req_valid_o;
   logic                       m_req_ready_i;
   logic [AddrWidth-1:0]       m_req_addr_o;
   logic                       m_req_we_o;
   logic [WideDataWidth-1:0]   m_req_wdata_o;
   logic [WideBeWidth-1:0]     m_req_be_o;
   logic                       m_rsp_valid_i;
   logic                       m_rsp_ready_o;
   logic [WideDataWidth-1:0]   m_rsp_rdata_i;
   logic                       m_rsp_err_i;

   // Shadow of the memory as the core sees it, and the responder's own copy
   logic [WideDataWidth-1:0]   shadow [MemWords];
   logic [WideDataWidth-1:0]   mem_model [MemWords];
   // Expected {err, data} per core request, in issue order
   logic [NarrowDataWidth:0]   exp_q [$];
   logic [WideDataWidth:0]     rsp_q [$];
   int                         issued_count = 0;
   int                         fwd_count = 0;
   int                         rsp_count = 0;
   int                         m_req_count = 0;
   logic                       hold_rsp;

   secure_ss_top UUT (
      .clk_i          ( clk_i          ),
      .rst_i          ( rst_i          ),
      .fetch_en_i     ( fetch_en_i     ),
      .irq_i          ( irq_i          ),
      .axi_isolate_i  ( axi_isolate_i  ),
      .fetch_en_o     ( fetch_en_o     ),
      .irq_o          ( irq_o          ),
      .axi_isolated_o ( axi_isolated_o ),
      .s_req_valid_i  ( s_req_valid_i  ),
      .s_req_ready_o  ( s_req_ready_o  ),
      .s_req_addr_i   ( s_req_addr_i   ),
      .s_req_we_i     ( s_req_we_i     ),
      .s_req_wdata_i  ( s_req_wdata_i  ),
      .s_req_be_i     ( s_req_be_i     ),
      .s_rsp_valid_o  ( s_rsp_valid_o  ),
      .s_rsp_ready_i  ( s_rsp_ready_i  ),
      .s_rsp_rdata_o  ( s_rsp_rdata_o  ),
      .s_rsp_err_o    ( s_rsp_err_o    ),
      .m_req_valid_o  ( m_req_valid_o  ),
      .m_req_ready_i  ( m_req_ready_i  ),
      .m_req_addr_o   ( m_req_addr_o   ),
      .m_req_we_o     ( m_req_we_o     ),
      .m_req_wdata_o  ( m_req_wdata_o  ),
      .m_req_be_o     ( m_req_be_o     ),
      .m_rsp_valid_i  ( m_rsp_valid_i  ),
      .m_rsp_ready_o  ( m_rsp_ready_o  ),
      .m_rsp_rdata_i  ( m_rsp_rdata_i  ),
      .m_rsp_err_i    ( m_rsp_err_i    )
   );

   initial begin
      clk_i = 1'b0;
      forever #(ClkPeriod / 2) clk_i = ~clk_i;
   end

   function automatic logic [WideDataWidth-1:0] fill_word(input int unsigned idx);
      return {32'h9e37_79b9 * idx + 32'h0000_1001, ~(32'h0101_0101 * idx)};
   endfunction

   // Address bit 2 picks the upper or lower half of the 64-bit word
   function automatic logic [NarrowDataWidth-1:0] ref_read(
      input logic [WideDataWidth-1:0] word,
      input logic [AddrWidth-1:0]     addr
   );
      if (addr[2]) begin
         return word[63:32];
      end else begin
         return word[31:0];
      end
   endfunction

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input logic [NarrowDataWidth-1:0] actual,
                             input logic [NarrowDataWidth-1:0] expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("Error: %s expected 0x%08h got 0x%08h", name, expected, actual));
      end
   endtask

   task automatic check_err(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
      end
   endtask

   task automatic check_flag(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         stop_on_error($sformatf("Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
      end
   endtask

   // Called on a falling edge, returns on the falling edge after the transfer
   task automatic send_req(input logic we, input logic [AddrWidth-1:0] addr,
                           input logic [NarrowDataWidth-1:0] wdata,
                           input logic [NarrowBeWidth-1:0] be, input logic exp_err);
      logic [NarrowDataWidth-1:0] exp_data;
      int                         b;
      s_req_valid_i = 1'b1;
      s_req_addr_i  = addr;
      s_req_we_i    = we;
      s_req_wdata_i = wdata;
      s_req_be_i    = be;
      #(Quarter);
      while (!s_req_ready_o) begin
         @(negedge clk_i);
         #(Quarter);
      end
      exp_data = '0;
      if (!exp_err) begin
         if (we) begin
            for (b = 0; b < NarrowBeWidth; b++) begin
               if (be[b] && addr[2]) begin
                  shadow[addr[7:3]][32 + b*8 +: 8] = wdata[b*8 +: 8];
               end else if (be[b]) begin
                  shadow[addr[7:3]][b*8 +: 8] = wdata[b*8 +: 8];
               end
            end
         end else begin
            exp_data = ref_read(shadow[addr[7:3]], addr);
         end
         fwd_count++;
      end
      exp_q.push_back({exp_err, exp_data});
      issued_count++;
      @(negedge clk_i);
      s_req_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      int cycles;
      cycles = 0;
      while (rsp_count != issued_count) begin
         @(negedge clk_i);
         cycles++;
         if (cycles > IdleBound) begin
            stop_on_error("Responses did not arrive in time");
         end
      end
   endtask

   task automatic wait_isolated(input logic level, input int bound);
      int cycles;
      cycles = 0;
      #(Quarter);
      while (axi_isolated_o !== level) begin
         @(negedge clk_i);
         #(Quarter);
         cycles++;
         if (cycles > bound) begin
            stop_on_error($sformatf("axi_isolated_o did not reach %0d in time", level));
         end
      end
      @(negedge clk_i);
   endtask

   task automatic check_sync_delay(input logic level);
      int c;
      fetch_en_i = level;
      irq_i      = level;
      for (c = 1; c <= SyncStages; c++) begin
         @(negedge clk_i);
         #(Quarter);
         check_flag("fetch_en_o", fetch_en_o, (c == SyncStages) ? level : !level);
         check_flag("irq_o", irq_o, (c == SyncStages) ? level : !level);
      end
      @(negedge clk_i);
   endtask

   task automatic run_traffic(input int n);
      logic [AddrWidth-1:0] addrs [$];
      logic [AddrWidth-1:0] addr;
      int                   i;
      for (i = 0; i < n; i++) begin
         addr = {24'h0, 6'($urandom), 2'b00};
         send_req(1'b1, addr, $urandom, 4'($urandom), 1'b0);
         addrs.push_back(addr);
         repeat ($urandom % 3) @(negedge clk_i);
      end
      // Newest first, then a few random words
      for (i = n - 1; i >= 0; i--) begin
         send_req(1'b0, addrs[i], '0, 4'hf, 1'b0);
         repeat ($urandom % 3) @(negedge clk_i);
      end
      for (i = 0; i < n / 4; i++) begin
         addr = {24'h0, 6'($urandom), 2'b00};
         send_req(1'b0, addr, '0, 4'hf, 1'b0);
      end
      wait_idle();
   endtask

   initial begin : main_seq
      int i;
      int cycles;
      int m_before;
      void'($urandom(Seed));
      rst_i         = 1'b1;
      fetch_en_i    = 1'b0;
      irq_i         = 1'b0;
      axi_isolate_i = 1'b1;
      s_req_valid_i = 1'b0;
      s_req_addr_i  = '0;
      s_req_we_i    = 1'b0;
      s_req_wdata_i = '0;
      s_req_be_i    = '0;
      hold_rsp      = 1'b0;
      for (i = 0; i < MemWords; i++) begin
         shadow[i]    = fill_word(i);
         mem_model[i] = fill_word(i);
      end
      repeat (ResetCycles) @(negedge clk_i);
      rst_i = 1'b0;

      #(Quarter);
      check_flag("axi_isolated_o", axi_isolated_o, 1'b1);
      check_flag("fetch_en_o", fetch_en_o, 1'b0);
      check_flag("irq_o", irq_o, 1'b0);
      check_flag("m_req_valid_o", m_req_valid_o, 1'b0);
      check_flag("s_rsp_valid_o", s_rsp_valid_o, 1'b0);
      @(negedge clk_i);
      axi_isolate_i = 1'b0;
      wait_isolated(1'b0, SyncBound);

      check_sync_delay(1'b1);
      check_sync_delay(1'b0);

      run_traffic(NumOps);

      // Keep responses back so the drain has something to wait for
      hold_rsp = 1'b1;
      for (i = 0; i < LaneFifoDepth; i++) begin
         send_req(i[0], {24'h0, 6'($urandom), 2'b00}, $urandom, 4'hf, 1'b0);
      end
      cycles = 0;
      while (m_req_count != fwd_count) begin
         @(negedge clk_i);
         cycles++;
         if (cycles > IdleBound) begin
            stop_on_error("Held requests never reached the outbound port");
         end
      end
      axi_isolate_i = 1'b1;
      repeat (2 * SyncStages + 2) @(negedge clk_i);
      #(Quarter);
      check_flag("axi_isolated_o", axi_isolated_o, 1'b0);
      @(negedge clk_i);
      hold_rsp = 1'b0;
      wait_isolated(1'b1, IdleBound);
      if (rsp_count != issued_count) begin
         stop_on_error("Isolation completed while responses were still outstanding");
      end

      m_before = m_req_count;
      send_req(1'b0, 32'h0000_0040, '0, 4'hf, 1'b1);
      send_req(1'b1, 32'h0000_0044, 32'hdead_beef, 4'hf, 1'b1);
      wait_idle();
      if (m_req_count != m_before) begin
         stop_on_error("Outbound request seen while isolated");
      end

      axi_isolate_i = 1'b0;
      wait_isolated(1'b0, SyncBound);
      run_traffic(NumOps);

      if (m_req_count == fwd_count && rsp_q.size() == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         stop_on_error("Outbound requests do not match the forwarded core requests");
      end
   end

   // 64-bit memory on the outbound port with random stalls and delays
   initial begin : responder
      logic [4:0]  idx;
      int          b;
      int unsigned rsp_wait;
      logic        rsp_fired;
      m_req_ready_i = 1'b0;
      m_rsp_valid_i = 1'b0;
      m_rsp_rdata_i = '0;
      m_rsp_err_i   = 1'b0;
      rsp_wait      = 0;
      rsp_fired     = 1'b0;
      forever begin
         @(negedge clk_i);
         if (rsp_fired) begin
            m_rsp_valid_i = 1'b0;
            rsp_wait      = $urandom % 4;
            rsp_fired     = 1'b0;
         end
         m_req_ready_i = ($urandom % 4) != 0;
         if (!m_rsp_valid_i && !hold_rsp && rsp_q.size() != 0) begin
            if (rsp_wait == 0) begin
               m_rsp_valid_i = 1'b1;
               m_rsp_err_i   = rsp_q[0][WideDataWidth];
               m_rsp_rdata_i = rsp_q[0][WideDataWidth-1:0];
            end else begin
               rsp_wait--;
            end
         end
         #(Quarter);
         if (m_req_valid_o && m_req_ready_i) begin
            idx = m_req_addr_o[7:3];
            if (m_req_we_o) begin
               for (b = 0; b < WideBeWidth; b++) begin
                  if (m_req_be_o[b]) begin
                     mem_model[idx][b*8 +: 8] = m_req_wdata_o[b*8 +: 8];
                  end
               end
               rsp_q.push_back({1'b0, 64'h0});
            end else begin
               rsp_q.push_back({1'b0, mem_model[idx]});
            end
            m_req_count++;
         end
         if (m_rsp_valid_i && m_rsp_ready_o) begin
            rsp_q.delete(0);
            rsp_fired = 1'b1;
         end
      end
   end

   // Every core-side response against the oldest unanswered request
   initial begin : compare_rsp
      logic [NarrowDataWidth:0] expected;
      s_rsp_ready_i = 1'b0;
      forever begin
         @(negedge clk_i);
         s_rsp_ready_i = ($urandom % 3) != 0;
         #(Quarter);
         if (s_rsp_valid_o && s_rsp_ready_i) begin
            if (rsp_count >= exp_q.size()) begin
               stop_on_error("Response arrived with no request outstanding");
            end
            expected = exp_q[rsp_count];
            check_data("s_rsp_rdata_o", s_rsp_rdata_o, expected[NarrowDataWidth-1:0]);
            check_err("s_rsp_err_o", s_rsp_err_o, expected[NarrowDataWidth]);
            rsp_count++;
         end
      end
   end

   initial begin : watchdog
      #(ClkPeriod * CycleBound * TotalTests);
      stop_on_error("Watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire
